// ==== common/pad_cfg_if.sv ====
// Static control bits only; they change solely on an APB write and carry no handshake
interface pad_cfg_if;

	// Exchange the two joysticks between port A and port B
	logic swap;

	// Paddle channels take over the direction and TR pins
	logic paddle_en;

	// Paddle position from the analog stick instead of the knob
	logic paddle_joy;

	// Free-running nibble toggle instead of TH-driven selection
	logic jp_region;

	modport source (
		output swap,
		output paddle_en,
		output paddle_joy,
		output jp_region
	);

	modport sink (
		input swap,
		input paddle_en,
		input paddle_joy,
		input jp_region
	);

endinterface

// ==== common/pad_pkg.sv ====
// Single clock domain; one APB control word at byte 0, two ports, tick rate tied to clk_sys
package pad_pkg;

	// ==============================
	// Sizes and rates
	// ==============================
	localparam int NUM_PADDLE_PORTS = 2;

	// Roughly 16 kHz paddle strobe from the system clock
	localparam int PADDLE_TICK_DIV = 3356;
	localparam int PADDLE_TICK_W = $clog2(PADDLE_TICK_DIV);

	localparam int APB_ADDR_W = 8;
	localparam int APB_DATA_W = 32;

	typedef logic [APB_ADDR_W-1:0] apb_addr_t;
	typedef logic [APB_DATA_W-1:0] apb_data_t;

	// ==============================
	// Register map
	// ==============================
	localparam apb_addr_t CTRL_ADDR = 8'h00;

	localparam int CTRL_SWAP_BIT = 0;
	localparam int CTRL_PADDLE_EN_BIT = 1;
	localparam int CTRL_PADDLE_JOY_BIT = 2;
	localparam int CTRL_JP_REGION_BIT = 3;

	// ==============================
	// Controller types
	// ==============================
	// Paddle position, low nibble goes out first
	typedef logic [7:0] pad_sample_t;
	typedef logic [3:0] pad_nibble_t;

	// Bit 0 upwards: right, left, down, up, TL, TR
	typedef logic [5:0] joy_t;
	// Same order as joy_t, active low
	typedef logic [5:0] port_pins_t;

	typedef struct packed {
		pad_sample_t sample;
		logic        th;
		logic        tick;
	} paddle_feed_t;

	typedef struct packed {
		pad_nibble_t nibble;
		logic        tr;
	} paddle_out_t;

endpackage

// ==== design/pad_config_apb.sv ====
// APB slave without wait states; only CTRL_ADDR is mapped, upper data bits read as zero
module pad_config_apb (
	input  logic               clk_sys,
	input  logic               RESET,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  pad_pkg::apb_addr_t paddr,
	input  pad_pkg::apb_data_t pwdata,
	output pad_pkg::apb_data_t prdata,
	output logic               pready,
	output logic               pslverr,
	pad_cfg_if.source          cfg
);
	import pad_pkg::*;

	logic      setup_phase;
	logic      access_phase;
	logic      addr_hit;
	logic      swap_q;
	logic      paddle_en_q;
	logic      paddle_joy_q;
	logic      jp_region_q;
	apb_data_t ctrl_word;

	assign setup_phase  = psel & ~penable;
	assign access_phase = psel & penable;
	assign addr_hit     = (paddr == CTRL_ADDR);

	// Every access phase completes in one cycle
	assign pready = access_phase;

	// Read-back word with the bits at their map positions
	always_comb begin
		ctrl_word = '0;
		ctrl_word[CTRL_SWAP_BIT]       = swap_q;
		ctrl_word[CTRL_PADDLE_EN_BIT]  = paddle_en_q;
		ctrl_word[CTRL_PADDLE_JOY_BIT] = paddle_joy_q;
		ctrl_word[CTRL_JP_REGION_BIT]  = jp_region_q;
	end

	// ==============================
	// Control register
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			swap_q       <= 1'b0;
			paddle_en_q  <= 1'b0;
			paddle_joy_q <= 1'b0;
			jp_region_q  <= 1'b0;
		end else if (access_phase && pwrite && addr_hit) begin
			swap_q       <= pwdata[CTRL_SWAP_BIT];
			paddle_en_q  <= pwdata[CTRL_PADDLE_EN_BIT];
			paddle_joy_q <= pwdata[CTRL_PADDLE_JOY_BIT];
			jp_region_q  <= pwdata[CTRL_JP_REGION_BIT];
		end
	end

	// Response is prepared in setup so it is stable for the whole access phase
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			prdata  <= '0;
			pslverr <= 1'b0;
		end else if (setup_phase) begin
			prdata  <= (addr_hit && !pwrite) ? ctrl_word : '0;
			pslverr <= ~addr_hit;
		end else begin
			prdata  <= '0;
			pslverr <= 1'b0;
		end
	end

	assign cfg.swap       = swap_q;
	assign cfg.paddle_en  = paddle_en_q;
	assign cfg.paddle_joy = paddle_joy_q;
	assign cfg.jp_region  = jp_region_q;

endmodule

// ==== design/pad_sample_source.sv ====
// Stick input is two's complement and is mapped to an unsigned position; tick phase restarts on RESET
module pad_sample_source (
	input  logic                  clk_sys,
	input  logic                  RESET,
	pad_cfg_if.sink               cfg,
	input  pad_pkg::pad_sample_t  knob_0,
	input  pad_pkg::pad_sample_t  knob_1,
	input  pad_pkg::pad_sample_t  stick_x_0,
	input  pad_pkg::pad_sample_t  stick_x_1,
	input  logic                  th_out_a,
	input  logic                  th_out_b,
	output pad_pkg::paddle_feed_t [pad_pkg::NUM_PADDLE_PORTS-1:0] feed
);
	import pad_pkg::*;

	pad_sample_t [NUM_PADDLE_PORTS-1:0] knob_in;
	pad_sample_t [NUM_PADDLE_PORTS-1:0] stick_in;
	pad_sample_t [NUM_PADDLE_PORTS-1:0] sample_q;
	logic [NUM_PADDLE_PORTS-1:0]        th_q;
	logic [PADDLE_TICK_W-1:0]           tick_cnt;
	logic                               tick;

	assign knob_in  = {knob_1, knob_0};
	assign stick_in = {stick_x_1, stick_x_0};

	// ==============================
	// Sample and TH capture
	// ==============================
	always_ff @(posedge clk_sys) begin
		for (int i = 0; i < NUM_PADDLE_PORTS; i++) begin
			if (cfg.paddle_joy) begin
				// Centre of the stick lands on 8'h80
				sample_q[i] <= {~stick_in[i][7], stick_in[i][6:0]};
			end else begin
				sample_q[i] <= knob_in[i];
			end
		end
	end

	// TH idles high on the console side
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			th_q <= '1;
		end else begin
			th_q <= {th_out_b, th_out_a};
		end
	end

	// ==============================
	// Paddle tick
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			tick_cnt <= '0;
		end else if (tick_cnt == PADDLE_TICK_W'(PADDLE_TICK_DIV - 1)) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign tick = (tick_cnt == '0);

	always_comb begin
		for (int i = 0; i < NUM_PADDLE_PORTS; i++) begin
			feed[i].sample = sample_q[i];
			feed[i].th     = th_q[i];
			feed[i].tick   = tick;
		end
	end

endmodule

// ==== design/paddle/paddle_nibble_mux.sv ====
// One paddle port; feed must come from registers, sample is taken as-is at the load point
module paddle_nibble_mux (
	input  logic                  clk_sys,
	input  logic                  RESET,
	pad_cfg_if.sink               cfg,
	input  pad_pkg::paddle_feed_t feed,
	output pad_pkg::paddle_out_t  pins
);
	import pad_pkg::*;

	pad_nibble_t nibble_q;
	pad_nibble_t high_q;
	logic        tr_q;
	logic        th_prev;
	logic        th_fall;
	logic        th_rise;

	assign th_fall = th_prev & ~feed.th;
	assign th_rise = ~th_prev & feed.th;

	// ==============================
	// Nibble sequencer
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			nibble_q <= '0;
			high_q   <= '0;
			tr_q     <= 1'b0;
			th_prev  <= 1'b1;
		end else begin
			// Tracked in both modes so a mode change sees no stale edge
			th_prev <= feed.th;

			if (cfg.jp_region) begin
				// Japanese paddle, TR marks which half is on the pins
				if (feed.tick) begin
					if (tr_q) begin
						high_q   <= feed.sample[7:4];
						nibble_q <= feed.sample[3:0];
						tr_q     <= 1'b0;
					end else begin
						nibble_q <= high_q;
						tr_q     <= 1'b1;
					end
				end
			end else begin
				// Export style, console picks the half with TH
				if (th_fall) begin
					high_q   <= feed.sample[7:4];
					nibble_q <= feed.sample[3:0];
					tr_q     <= 1'b0;
				end else if (th_rise) begin
					nibble_q <= high_q;
					tr_q     <= 1'b0;
				end
			end
		end
	end

	assign pins.nibble = nibble_q;
	assign pins.tr     = tr_q;

endmodule

// ==== design/port_pin_mux.sv ====
// Registered pins; TH is an input to the pad logic and is not driven back here
module port_pin_mux (
	input  logic                 clk_sys,
	input  logic                 RESET,
	pad_cfg_if.sink              cfg,
	input  pad_pkg::joy_t        joy_0,
	input  pad_pkg::joy_t        joy_1,
	input  pad_pkg::paddle_out_t [pad_pkg::NUM_PADDLE_PORTS-1:0] paddle,
	output pad_pkg::port_pins_t  port_a,
	output pad_pkg::port_pins_t  port_b
);
	import pad_pkg::*;

	joy_t joy_a;
	joy_t joy_b;

	// Joystick pins, with the paddle nibble over the directions when enabled
	function automatic port_pins_t drive_pins(joy_t joy, paddle_out_t pad, logic use_pad);
		port_pins_t pins;
		pins = ~joy;
		if (use_pad) begin
			// Nibble goes on the data lines as-is
			pins[3] = pad.nibble[0];
			pins[2] = pad.nibble[1];
			pins[1] = pad.nibble[2];
			pins[0] = pad.nibble[3];
			pins[5] = pad.tr;
		end
		return pins;
	endfunction

	assign joy_a = cfg.swap ? joy_1 : joy_0;
	assign joy_b = cfg.swap ? joy_0 : joy_1;

	// ==============================
	// Output pins
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			// Released
			port_a <= '1;
			port_b <= '1;
		end else begin
			port_a <= drive_pins(joy_a, paddle[0], cfg.paddle_en);
			port_b <= drive_pins(joy_b, paddle[1], cfg.paddle_en);
		end
	end

endmodule

// ==== design/sms_pad_ports.sv ====
// Two controller ports on one clock; export-mode TH edges reach the pins three cycles later
module sms_pad_ports (
	input  logic                 clk_sys,
	input  logic                 RESET,

	// APB control port
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  pad_pkg::apb_addr_t   paddr,
	input  pad_pkg::apb_data_t   pwdata,
	output pad_pkg::apb_data_t   prdata,
	output logic                 pready,
	output logic                 pslverr,

	// Controller sources
	input  pad_pkg::joy_t        joy_0,
	input  pad_pkg::joy_t        joy_1,
	input  pad_pkg::pad_sample_t knob_0,
	input  pad_pkg::pad_sample_t knob_1,
	input  pad_pkg::pad_sample_t stick_x_0,
	input  pad_pkg::pad_sample_t stick_x_1,

	// Console side
	input  logic                 th_out_a,
	input  logic                 th_out_b,
	output pad_pkg::port_pins_t  port_a,
	output pad_pkg::port_pins_t  port_b
);
	import pad_pkg::*;

	paddle_feed_t [NUM_PADDLE_PORTS-1:0] feed;
	paddle_out_t [NUM_PADDLE_PORTS-1:0]  pad_out;

	pad_cfg_if cfg_bus ();

	pad_config_apb u_config (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.cfg     (cfg_bus)
	);

	pad_sample_source u_source (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.cfg       (cfg_bus),
		.knob_0    (knob_0),
		.knob_1    (knob_1),
		.stick_x_0 (stick_x_0),
		.stick_x_1 (stick_x_1),
		.th_out_a  (th_out_a),
		.th_out_b  (th_out_b),
		.feed      (feed)
	);

	// ==============================
	// Paddle channels
	// ==============================
	for (genvar ch = 0; ch < NUM_PADDLE_PORTS; ch++) begin : g_paddle
		paddle_nibble_mux u_chan (
			.clk_sys (clk_sys),
			.RESET   (RESET),
			.cfg     (cfg_bus),
			.feed    (feed[ch]),
			.pins    (pad_out[ch])
		);
	end

	port_pin_mux u_pins (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.cfg     (cfg_bus),
		.joy_0   (joy_0),
		.joy_1   (joy_1),
		.paddle  (pad_out),
		.port_a  (port_a),
		.port_b  (port_b)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sms_pad_ports \
	-f sms_pad_ports.f -o sim_tb_sms_pad_ports \
	|| { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/sim_tb_sms_pad_ports 2>&1)"
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qF "=== PASS ===" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== sms_pad_ports.f ====
common/pad_pkg.sv
common/pad_cfg_if.sv
design/pad_config_apb.sv
design/pad_sample_source.sv
design/paddle/paddle_nibble_mux.sv
design/port_pin_mux.sv
design/sms_pad_ports.sv
tests/sms_pad_ports_properties.sv
tests/tb_sms_pad_ports.sv

// ==== tests/pad_stimulus.txt ====
// Columns: op arg0 arg1 arg2 arg3, all hex, unused arguments 0; ops 1 write addr data, 2 read addr data err
// 3 joy j0 j1, 4 knob k0 k1 s0 s1, 5 th a b, 6 wait n, 7 expect lat a b, 8 jp port n, 9 random n, F end
// Register access
2 00 00000000 0 0
1 00 FFFFFFFF 0 0
2 00 0000000F 0 0
1 04 00000000 0 0
2 04 00000000 1 0
2 10 00000000 1 0
2 00 0000000F 0 0
1 00 00000000 0 0
2 00 00000000 0 0
// Joysticks, paddle disabled, then swapped
3 01 22 0 0
7 1 3E 1D 0
9 40 0 0 0
1 00 00000001 0 0
3 05 30 0 0
7 1 0F 3A 0
9 40 0 0 0
// Export paddle from the knobs
1 00 00000002 0 0
3 10 00 0 0
4 A5 3C 00 00
6 4 0 0 0
5 0 0 0 0
7 3 0A 13 0
5 1 1 0 0
7 3 05 1C 0
3 0F 3F 0 0
7 1 15 0C 0
4 96 3C 00 00
6 2 0 0 0
5 0 1 0 0
7 3 16 0C 0
5 1 1 0 0
7 3 19 0C 0
// Japanese paddle from the knobs, then from the sticks
1 00 0000000A 0 0
6 1B58 0 0 0
8 0 1B58 0 0
8 1 1B58 0 0
1 00 0000000E 0 0
4 96 3C 2B E7
6 1B58 0 0 0
8 0 1B58 0 0
8 1 1B58 0 0
// Paddle disabled again
1 00 00000000 0 0
7 1 30 00 0
9 20 0 0 0
2 00 00000000 0 0
F 0 0 0 0

// ==== tests/sms_pad_ports_properties.sv ====
// Bound into sms_pad_ports; the follow check covers port A only, with paddle and swap clear
module sms_pad_ports_properties (
	input logic                clk_sys,
	input logic                RESET,
	input logic                psel,
	input logic                penable,
	input logic                pready,
	input logic                swap,
	input logic                paddle_en,
	input pad_pkg::joy_t       joy_0,
	input pad_pkg::port_pins_t port_a,
	input pad_pkg::port_pins_t port_b
);

	// No wait states on the APB side
	a_pready: assert property (@(posedge clk_sys) disable iff (RESET)
		(psel && penable) |-> pready)
		else $error("pready low during an APB access phase");

	// Released pins straight out of reset
	a_reset_released: assert property (@(posedge clk_sys)
		RESET |=> (port_a == '1 && port_b == '1))
		else $error("Port pins not all ones after a reset cycle");

	a_joy_follow: assert property (@(posedge clk_sys) disable iff (RESET)
		(!paddle_en && !swap) |=> (port_a == ~$past(joy_0)))
		else $error("port_a does not follow the inverted joy_0 of the previous cycle");

endmodule

bind sms_pad_ports sms_pad_ports_properties u_props (
	.clk_sys   (clk_sys),
	.RESET     (RESET),
	.psel      (psel),
	.penable   (penable),
	.pready    (pready),
	.swap      (cfg_bus.swap),
	.paddle_en (cfg_bus.paddle_en),
	.joy_0     (joy_0),
	.port_a    (port_a),
	.port_b    (port_b)
);

// ==== tests/tb_sms_pad_ports.sv ====
// Must run from the project root; each stimulus row is five hex words, an op and four arguments
module tb_sms_pad_ports;
	import pad_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 5;
	localparam int ROW_WORDS    = 5;
	localparam int MAX_ROWS     = 64;
	localparam int LINE_BUDGET  = 20;
	localparam string STIM_FILE = "tests/pad_stimulus.txt";

	// Pin positions inside port_pins_t
	localparam int PIN_RIGHT = 0;
	localparam int PIN_LEFT  = 1;
	localparam int PIN_DOWN  = 2;
	localparam int PIN_UP    = 3;
	localparam int PIN_TR    = 5;

	// Stimulus op codes
	localparam logic [31:0] OP_WRITE    = 32'h1;
	localparam logic [31:0] OP_READ     = 32'h2;
	localparam logic [31:0] OP_JOY      = 32'h3;
	localparam logic [31:0] OP_KNOB     = 32'h4;
	localparam logic [31:0] OP_TH       = 32'h5;
	localparam logic [31:0] OP_WAIT     = 32'h6;
	localparam logic [31:0] OP_EXPECT   = 32'h7;
	localparam logic [31:0] OP_JP_CHECK = 32'h8;
	localparam logic [31:0] OP_RANDOM   = 32'h9;
	localparam logic [31:0] OP_END      = 32'hF;

	logic        clk_sys;
	logic        RESET;
	logic        psel;
	logic        penable;
	logic        pwrite;
	apb_addr_t   paddr;
	apb_data_t   pwdata;
	apb_data_t   prdata;
	logic        pready;
	logic        pslverr;
	joy_t        joy_0;
	joy_t        joy_1;
	pad_sample_t knob_0;
	pad_sample_t knob_1;
	pad_sample_t stick_x_0;
	pad_sample_t stick_x_1;
	logic        th_out_a;
	logic        th_out_b;
	port_pins_t  port_a;
	port_pins_t  port_b;

	logic [31:0] stim_mem [0:ROW_WORDS*MAX_ROWS-1];
	apb_data_t   ctrl_model;
	logic [31:0] lcg_state;
	int          error_count;
	int          watchdog_cycles;
	logic        budget_ready = 1'b0;

	sms_pad_ports uut (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.joy_0     (joy_0),
		.joy_1     (joy_1),
		.knob_0    (knob_0),
		.knob_1    (knob_1),
		.stick_x_0 (stick_x_0),
		.stick_x_1 (stick_x_1),
		.th_out_a  (th_out_a),
		.th_out_b  (th_out_b),
		.port_a    (port_a),
		.port_b    (port_b)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD/2) clk_sys = ~clk_sys;
	end

	// ==============================
	// Checks
	// ==============================
	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_pins(string name, port_pins_t exp, port_pins_t act);
		if (act !== exp) begin
			error_count++;
			$display("FAILED at time %0t: %s expected %h, actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_apb_data(string name, apb_data_t exp, apb_data_t act);
		if (act !== exp) begin
			error_count++;
			$display("FAILED at time %0t: %s expected %h, actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp) begin
			error_count++;
			$display("FAILED at time %0t: %s expected %b, actual %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	// ==============================
	// Reference model
	// ==============================
	function automatic logic [31:0] lcg_next(logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic joy_t routed_joy(int port);
		logic swap;
		swap = ctrl_model[CTRL_SWAP_BIT];
		if (port == 0) begin
			return swap ? joy_1 : joy_0;
		end
		return swap ? joy_0 : joy_1;
	endfunction

	function automatic port_pins_t joystick_pins(joy_t joy);
		return ~joy;
	endfunction

	// Up, down, left, right carry nibble bits 0 to 3, TR carries the half flag
	function automatic port_pins_t paddle_pins(joy_t joy, pad_nibble_t nib, logic tr);
		port_pins_t pins;
		pins = ~joy;
		pins[PIN_UP]    = nib[0];
		pins[PIN_DOWN]  = nib[1];
		pins[PIN_LEFT]  = nib[2];
		pins[PIN_RIGHT] = nib[3];
		pins[PIN_TR]    = tr;
		return pins;
	endfunction

	// Stick is two's complement, flipping the sign bit gives the position
	function automatic pad_sample_t expected_sample(int port);
		pad_sample_t knob;
		pad_sample_t stick;
		knob  = (port == 0) ? knob_0 : knob_1;
		stick = (port == 0) ? stick_x_0 : stick_x_1;
		return ctrl_model[CTRL_PADDLE_JOY_BIT] ? (stick ^ 8'h80) : knob;
	endfunction

	function automatic int stimulus_budget();
		int          cycles;
		int          row;
		logic        done;
		logic [31:0] op;
		cycles = RESET_CYCLES;
		row    = 0;
		done   = 1'b0;
		while (!done && row < MAX_ROWS) begin
			op     = stim_mem[row*ROW_WORDS];
			cycles += LINE_BUDGET;
			if (op == OP_WAIT || op == OP_EXPECT) begin
				cycles += int'(stim_mem[row*ROW_WORDS+1]);
			end else if (op == OP_JP_CHECK) begin
				cycles += int'(stim_mem[row*ROW_WORDS+2]);
			end else if (op == OP_RANDOM) begin
				cycles += 2 * int'(stim_mem[row*ROW_WORDS+1]);
			end
			done = (op == OP_END);
			row++;
		end
		return done ? cycles : -1;
	endfunction

	// ==============================
	// Drivers
	// ==============================
	task automatic apb_write(apb_addr_t addr, apb_data_t data);
		@(negedge clk_sys);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk_sys);
		penable = 1'b1;
		#(CLK_PERIOD/4);
		check_flag("pready", 1'b1, pready);
		check_flag("pslverr", addr != CTRL_ADDR, pslverr);
		@(negedge clk_sys);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		// Only the four defined bits are stored
		if (addr == CTRL_ADDR) begin
			ctrl_model = '0;
			ctrl_model[CTRL_SWAP_BIT]       = data[CTRL_SWAP_BIT];
			ctrl_model[CTRL_PADDLE_EN_BIT]  = data[CTRL_PADDLE_EN_BIT];
			ctrl_model[CTRL_PADDLE_JOY_BIT] = data[CTRL_PADDLE_JOY_BIT];
			ctrl_model[CTRL_JP_REGION_BIT]  = data[CTRL_JP_REGION_BIT];
		end
	endtask

	task automatic apb_read(apb_addr_t addr, apb_data_t exp_data, logic exp_err);
		@(negedge clk_sys);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(negedge clk_sys);
		penable = 1'b1;
		#(CLK_PERIOD/4);
		check_flag("pready", 1'b1, pready);
		check_apb_data("prdata", exp_data, prdata);
		check_flag("pslverr", exp_err, pslverr);
		@(negedge clk_sys);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// Every cycle the shown half must match TR, and both halves must turn up
	task automatic jp_check(int port, int cycles);
		string       name;
		logic        seen_low;
		logic        seen_high;
		pad_sample_t smp;
		pad_nibble_t nib;
		port_pins_t  act;
		name      = (port == 0) ? "port_a" : "port_b";
		seen_low  = 1'b0;
		seen_high = 1'b0;
		smp       = expected_sample(port);
		repeat (cycles) begin
			@(negedge clk_sys);
			act = (port == 0) ? port_a : port_b;
			nib = act[PIN_TR] ? smp[7:4] : smp[3:0];
			if (act[PIN_TR]) begin
				seen_high = 1'b1;
			end else begin
				seen_low = 1'b1;
			end
			check_pins(name, paddle_pins(routed_joy(port), nib, act[PIN_TR]), act);
		end
		if (!(seen_low && seen_high)) begin
			error_count++;
			$display("Japanese paddle on %s did not show both TR states in %0d cycles",
				name, cycles);
			abort_run();
		end
	endtask

	task automatic random_joy_run(int count);
		repeat (count) begin
			lcg_state = lcg_next(lcg_state);
			@(negedge clk_sys);
			joy_0 = lcg_state[29:24];
			joy_1 = lcg_state[21:16];
			@(negedge clk_sys);
			check_pins("port_a", joystick_pins(routed_joy(0)), port_a);
			check_pins("port_b", joystick_pins(routed_joy(1)), port_b);
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin : main
		int          fd;
		int          row;
		logic [31:0] op;
		logic [31:0] a0;
		logic [31:0] a1;
		logic [31:0] a2;
		logic [31:0] a3;
		RESET       = 1'b1;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		joy_0       = '0;
		joy_1       = '0;
		knob_0      = '0;
		knob_1      = '0;
		stick_x_0   = '0;
		stick_x_1   = '0;
		th_out_a    = 1'b1;
		th_out_b    = 1'b1;
		ctrl_model  = '0;
		lcg_state   = 32'h5635_2c6b;
		error_count = 0;

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file %s", STIM_FILE);
			abort_run();
		end
		$fclose(fd);
		$readmemh(STIM_FILE, stim_mem);
		watchdog_cycles = stimulus_budget();
		if (watchdog_cycles < 0) begin
			$display("The stimulus file has no end row within %0d rows", MAX_ROWS);
			abort_run();
		end
		budget_ready = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;

		row = 0;
		op  = stim_mem[0];
		while (op != OP_END) begin
			a0 = stim_mem[row*ROW_WORDS+1];
			a1 = stim_mem[row*ROW_WORDS+2];
			a2 = stim_mem[row*ROW_WORDS+3];
			a3 = stim_mem[row*ROW_WORDS+4];
			case (op)
				OP_WRITE: apb_write(a0[7:0], a1);
				OP_READ:  apb_read(a0[7:0], a1, a2[0]);
				OP_JOY: begin
					@(negedge clk_sys);
					joy_0 = a0[5:0];
					joy_1 = a1[5:0];
				end
				OP_KNOB: begin
					@(negedge clk_sys);
					knob_0    = a0[7:0];
					knob_1    = a1[7:0];
					stick_x_0 = a2[7:0];
					stick_x_1 = a3[7:0];
				end
				OP_TH: begin
					@(negedge clk_sys);
					th_out_a = a0[0];
					th_out_b = a1[0];
				end
				OP_WAIT: repeat (a0) @(negedge clk_sys);
				OP_EXPECT: begin
					repeat (a0) @(negedge clk_sys);
					check_pins("port_a", a1[5:0], port_a);
					check_pins("port_b", a2[5:0], port_b);
				end
				OP_JP_CHECK: jp_check(int'(a0), int'(a1));
				OP_RANDOM:   random_joy_run(int'(a0));
				default: begin
					error_count++;
					$display("Unknown op %h in stimulus row %0d", op, row);
					abort_run();
				end
			endcase
			row++;
			op = stim_mem[row*ROW_WORDS];
		end

		@(negedge clk_sys);
		if (error_count == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("=== FAIL ===");
			$fatal(1, "%0d checks failed", error_count);
		end
	end

	// Budget comes from the stimulus rows
	initial begin : watchdog
		wait (budget_ready === 1'b1);
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("Timeout: the stimulus did not finish within %0d cycles", watchdog_cycles);
		abort_run();
	end

endmodule
